/* hdl/i2c_consts.svh */
/*
 * I2C master constants
 * clock rates, bus field widths and the SCL half-period divider
 */
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

`define I2C_SYS_CLK_HZ 10_000_000  // system clock
`define I2C_SPEED_HZ   1_000_000   // SCL bit rate

// system clocks per SCL half period, rounded up
`define I2C_HALF_DIV ((`I2C_SYS_CLK_HZ + 2 * `I2C_SPEED_HZ - 1) / (2 * `I2C_SPEED_HZ))

`define I2C_ADDR_W 7
`define I2C_BYTE_W 8
`define I2C_LEN_W  8  // byte counts for write and read

`endif

/* hdl/i2c_bus_pkg.sv */
/*
 * I2C bus types
 * pin drive requests, synchronized pin levels and the bit sequencer states
 */
`default_nettype none

package i2c_bus_pkg;

    typedef struct packed {
        logic sda_low;  // pull SDA low, else release
        logic scl_low;
    } line_drive_t;

    typedef struct packed {
        logic sda;
        logic scl;
        logic scl_rise;  // one cycle on synchronized SCL rising
    } line_sense_t;

    typedef enum logic [3:0] {
        idle, start_hi, start_fall, start_hold, addr_load, byte_load, bit_low, bit_high,
        ack_low, ack_high, ack_check, restart, stop_prep, stop_rise, done_st
    } seq_state_e;

endpackage

`default_nettype wire

/* hdl/i2c_xfer_pkg.sv */
/*
 * I2C transaction types
 * command, status, phase flags and remaining byte counts
 */
`default_nettype none

`include "i2c_consts.svh"

package i2c_xfer_pkg;

    typedef struct packed {
        logic [`I2C_ADDR_W-1:0] addr;
        logic [`I2C_LEN_W-1:0]  wr_len;
        logic [`I2C_LEN_W-1:0]  rd_len;
    } xfer_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;       // one cycle at the end
        logic nack_addr;
        logic nack_data;
    } xfer_status_t;

    typedef struct packed {
        logic do_write;   // write phase active
        logic do_read;    // read phase active
        logic do_both;    // write then repeated START then read
        logic addr_byte;  // current byte is the address
    } xfer_phase_t;

    typedef struct packed {
        logic tx_left;
        logic rx_left;
        logic more_rx;    // next read byte is not the last
    } xfer_counts_t;

endpackage

`default_nettype wire

/* hdl/i2c_pin_sync.sv */
/*
 * I2C pin interface
 * open-drain drivers for SDA and SCL, two-flop input synchronizers
 * and SCL rising-edge detection
 */
`timescale 1ns/100ps
`default_nettype none

module i2c_pin_sync (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire i2c_bus_pkg::line_drive_t drive,
    output i2c_bus_pkg::line_sense_t      sense,
    inout  tri                           sda_io,
    inout  tri                           scl_io
);

    logic [1:0] meta_q;  // {sda, scl}
    logic [1:0] sync_q;
    logic       scl_prev;

    // only ever pull low, the pull-ups make the high level
    assign sda_io = drive.sda_low ? 1'b0 : 1'bz;
    assign scl_io = drive.scl_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q   <= '1;  // idle bus reads high
            sync_q   <= '1;
            scl_prev <= 1'b1;
        end else begin
            meta_q   <= {sda_io, scl_io};
            sync_q   <= meta_q;
            scl_prev <= sync_q[0];
        end
    end

    assign sense = '{sda: sync_q[1], scl: sync_q[0], scl_rise: sync_q[0] & ~scl_prev};

endmodule

`default_nettype wire

/* hdl/i2c_bit_timer.sv */
/*
 * SCL half-period timer
 * free-running, pulses tick once every div system clocks
 */
`timescale 1ns/100ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_bit_timer #(
    parameter int div = `I2C_HALF_DIV  // 2 or more
) (
    input  wire logic clk,
    input  wire logic rst_n,
    output logic      tick
);

    localparam int cnt_w = $clog2(div);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_w'(div - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/i2c_cmd_regs.sv */
/*
 * I2C command registers
 * start edge detection and launch, latched command, transaction phase
 * flags and remaining byte counters, stepped by the sequencer state
 */
`timescale 1ns/100ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_cmd_regs (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start,
    input  wire i2c_xfer_pkg::xfer_cmd_t    cmd,
    input  wire i2c_bus_pkg::seq_state_e    state,
    output logic                           launch,
    output i2c_xfer_pkg::xfer_cmd_t         cmd_q,
    output i2c_xfer_pkg::xfer_phase_t       phase,
    output i2c_xfer_pkg::xfer_counts_t      counts
);
    import i2c_bus_pkg::*;

    logic                  start_q;
    logic                  start_qq;
    logic                  go;
    logic                  check_q;  // was in ack_check last cycle
    logic [`I2C_LEN_W-1:0] tx_rem;
    logic [`I2C_LEN_W-1:0] rx_rem;

    // rising start, sequencer idle, something to move
    assign go = start_q & ~start_qq & (state == idle) &
                ((cmd.wr_len != '0) | (cmd.rd_len != '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q  <= 1'b0;
            start_qq <= 1'b0;
            launch   <= 1'b0;
        end else begin
            start_q  <= start;
            start_qq <= start_q;
            launch   <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) cmd_q <= cmd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= '0;
            tx_rem  <= '0;
            rx_rem  <= '0;
            check_q <= 1'b0;
        end else begin
            check_q <= (state == ack_check);
            if (launch) begin
                phase.do_write  <= (cmd_q.wr_len != '0);
                phase.do_read   <= (cmd_q.rd_len != '0) && (cmd_q.wr_len == '0);
                phase.do_both   <= (cmd_q.rd_len != '0) && (cmd_q.wr_len != '0);
                phase.addr_byte <= 1'b0;
                tx_rem          <= cmd_q.wr_len;
                rx_rem          <= cmd_q.rd_len;
            end else begin
                case (state)
                    idle: begin
                        phase  <= '0;
                        tx_rem <= '0;
                        rx_rem <= '0;
                    end
                    addr_load: phase.addr_byte <= 1'b1;
                    ack_check: if (!check_q) begin  // once per ACK slot
                        if (phase.addr_byte)
                            phase.addr_byte <= 1'b0;
                        else if (phase.do_write && tx_rem != '0)
                            tx_rem <= tx_rem - 1'b1;
                        else if (phase.do_read && rx_rem != '0)
                            rx_rem <= rx_rem - 1'b1;
                    end
                    restart: begin  // read phase of a combined transfer
                        phase.do_write <= 1'b0;
                        phase.do_read  <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign counts = '{tx_left: (tx_rem != '0), rx_left: (rx_rem != '0), more_rx: (rx_rem > 1)};

endmodule

`default_nettype wire

/* hdl/i2c_bit_sequencer.sv */
/*
 * I2C bit sequencer
 * FSM for START, address and data bits, ACK/NACK, repeated START and STOP.
 * Waits for SCL to rise on every high phase and holds SCL low while
 * the write stream is empty or the read stream is stalled.
 */
`timescale 1ns/100ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_bit_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      tick,
    input  wire logic                      launch,
    input  wire i2c_bus_pkg::line_sense_t   sense,
    input  wire i2c_xfer_pkg::xfer_cmd_t    cmd_q,
    input  wire i2c_xfer_pkg::xfer_phase_t  phase,
    input  wire i2c_xfer_pkg::xfer_counts_t counts,
    output i2c_bus_pkg::line_drive_t        drive,
    output i2c_bus_pkg::seq_state_e         state,
    output i2c_xfer_pkg::xfer_status_t      status,
    input  wire logic [`I2C_BYTE_W-1:0]    wr_data,
    input  wire logic                      wr_valid,
    input  wire logic                      rd_ready,
    output logic                           wr_ready,
    output logic [`I2C_BYTE_W-1:0]         rd_data,
    output logic                           rd_valid
);
    import i2c_bus_pkg::*;

    seq_state_e             next;
    logic [`I2C_BYTE_W-1:0] shift_q;  // outgoing bits, MSB first
    logic [`I2C_BYTE_W-1:0] rx_q;
    logic [3:0]             bit_cnt;
    logic                   scl_seen;  // SCL has risen in this high phase
    logic                   settled;   // counts updated for this ACK slot
    logic                   nack_addr;
    logic                   nack_data;
    logic                   sending;
    logic                   stall;
    logic                   wr_take;
    logic                   rx_done;

    assign sending  = phase.addr_byte | phase.do_write;
    assign stall    = rd_valid & ~rd_ready;
    assign wr_ready = (state == byte_load);
    assign wr_take  = wr_valid & wr_ready;
    assign rx_done  = (state == bit_high) && (next == ack_low) && !sending;

    assign status = '{busy: (state != idle), done: (state == done_st),
                      nack_addr: nack_addr, nack_data: nack_data};

    always_comb begin
        next = state;
        case (state)
            idle:       if (launch) next = start_hi;
            start_hi:   if (tick && sense.scl && sense.sda) next = start_fall;
            start_fall: next = start_hold;
            start_hold: if (tick) next = addr_load;
            addr_load:  next = bit_low;
            byte_load:  if (wr_take) next = bit_low;
            bit_low:    if (tick) next = bit_high;
            bit_high:   if (tick && scl_seen) next = (bit_cnt == 4'd8) ? ack_low : bit_low;
            ack_low:    if (tick) next = ack_high;
            ack_high:   if (tick && scl_seen) next = ack_check;
            ack_check: begin
                if (settled && !stall) begin
                    if (nack_addr || nack_data)
                        next = stop_prep;
                    else if (phase.do_both && phase.do_write && !counts.tx_left)
                        next = restart;
                    else if (phase.do_write)
                        next = counts.tx_left ? byte_load : stop_prep;
                    else
                        next = counts.rx_left ? bit_low : stop_prep;
                end
            end
            restart:    if (tick) next = start_hi;
            stop_prep:  if (tick) next = stop_rise;
            stop_rise:  if (tick && sense.scl) next = done_st;
            done_st:    next = idle;
            default:    next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            drive     <= '0;  // both lines released
            bit_cnt   <= '0;
            scl_seen  <= 1'b0;
            settled   <= 1'b0;
            nack_addr <= 1'b0;
            nack_data <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            state   <= next;
            settled <= (state == ack_check);

            drive.scl_low <= next inside {addr_load, byte_load, bit_low, ack_low,
                                          ack_check, restart, stop_prep};

            // SDA moves one cycle after SCL is already low
            case (state)
                bit_low:   drive.sda_low <= sending & ~shift_q[`I2C_BYTE_W-1];
                ack_low:   drive.sda_low <= ~sending & counts.more_rx;  // ACK unless last
                restart:   drive.sda_low <= 1'b0;
                stop_prep: drive.sda_low <= 1'b1;
                default: ;
            endcase
            if (next inside {idle, start_hi, done_st})
                drive.sda_low <= 1'b0;
            else if (next inside {start_fall, start_hold})
                drive.sda_low <= 1'b1;  // START while SCL high

            if (state inside {bit_low, ack_low})
                scl_seen <= 1'b0;
            else if (sense.scl_rise)
                scl_seen <= 1'b1;

            if (state inside {addr_load, ack_low})
                bit_cnt <= '0;
            else if (state == bit_high && sense.scl_rise)
                bit_cnt <= bit_cnt + 1'b1;

            if (next == idle) begin
                nack_addr <= 1'b0;
                nack_data <= 1'b0;
            end else if (state == ack_high && sense.scl_rise) begin
                if (phase.addr_byte)
                    nack_addr <= sense.sda;
                else if (phase.do_write)
                    nack_data <= sense.sda;
            end

            if (rx_done)
                rd_valid <= 1'b1;  // offered at the start of the ACK slot
            else if (rd_ready)
                rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == addr_load)
            shift_q <= {cmd_q.addr, phase.do_read};  // R/W bit last
        else if (wr_take)
            shift_q <= wr_data;
        else if (state == bit_high && sense.scl_rise && sending)
            shift_q <= {shift_q[`I2C_BYTE_W-2:0], 1'b0};

        if (state == bit_high && sense.scl_rise && !sending)
            rx_q <= {rx_q[`I2C_BYTE_W-2:0], sense.sda};

        if (rx_done) rd_data <= rx_q;
    end

endmodule

`default_nettype wire

/* hdl/i2c_master.sv */
/*
 * I2C master, 7-bit addressing
 * write, read or write then repeated START and read, with valid/ready
 * byte streams and open-drain SDA/SCL
 */
`timescale 1ns/100ps
`default_nettype none

`include "i2c_consts.svh"

module i2c_master (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire i2c_xfer_pkg::xfer_cmd_t cmd,
    output i2c_xfer_pkg::xfer_status_t   status,
    input  wire logic [`I2C_BYTE_W-1:0] wr_data,
    input  wire logic                   wr_valid,
    output logic                        wr_ready,
    output logic [`I2C_BYTE_W-1:0]      rd_data,
    output logic                        rd_valid,
    input  wire logic                   rd_ready,
    inout  tri                          sda_io,
    inout  tri                          scl_io
);
    import i2c_bus_pkg::*;
    import i2c_xfer_pkg::*;

    line_drive_t  drive;
    line_sense_t  sense;
    logic         tick;
    logic         launch;
    seq_state_e   state;
    xfer_cmd_t    cmd_q;
    xfer_phase_t  phase;
    xfer_counts_t counts;

    i2c_pin_sync u_pins (
        .clk    (clk),
        .rst_n  (rst_n),
        .drive  (drive),
        .sense  (sense),
        .sda_io (sda_io),
        .scl_io (scl_io)
    );

    i2c_bit_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    i2c_cmd_regs u_cmd (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .cmd    (cmd),
        .state  (state),
        .launch (launch),
        .cmd_q  (cmd_q),
        .phase  (phase),
        .counts (counts)
    );

    i2c_bit_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .launch   (launch),
        .sense    (sense),
        .cmd_q    (cmd_q),
        .phase    (phase),
        .counts   (counts),
        .drive    (drive),
        .state    (state),
        .status   (status),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .rd_ready (rd_ready),
        .wr_ready (wr_ready),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

/* dv/i2c_slave_model.sv */
/*
 * Behavioral I2C target
 * answers one 7-bit address, logs written bytes, the R/W bit of each
 * address phase and the master's ACK bits, serves read byte i as A5 xor i
 */
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] addr = 7'h52
) (
    input  wire logic       clk,
    input  wire logic       clear,    // empties the logs
    input  wire logic [7:0] nack_at,  // write byte index to refuse, ff for none
    inout  tri              sda_io,
    inout  tri              scl_io
);

    localparam logic [1:0] m_idle  = 2'd0;
    localparam logic [1:0] m_addr  = 2'd1;
    localparam logic [1:0] m_write = 2'd2;
    localparam logic [1:0] m_read  = 2'd3;
    localparam logic [7:0] rd_first = 8'hA5;

    logic [7:0] wr_log[$];
    logic       ack_log[$];  // 0 is ACK from the master
    logic       rw_log[$];
    int         starts;

    logic       sda_low;
    logic       sda_q;
    logic       scl_q;
    logic [1:0] mode;
    logic [3:0] bit_cnt;  // 8 is the ACK slot, 9 while our ACK is driven
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [7:0] rd_idx;

    assign sda_io = sda_low ? 1'b0 : 1'bz;

    initial begin
        sda_low = 1'b0;
        sda_q   = 1'b1;
        scl_q   = 1'b1;
        mode    = m_idle;
        bit_cnt = '0;
        starts  = 0;
    end

    // lines are sampled on the system clock, so a bit and an SCL edge
    // moving in the same cycle are seen together
    always @(posedge clk) begin
        sda_q <= sda_io;
        scl_q <= scl_io;
        if (clear) begin
            wr_log.delete();
            ack_log.delete();
            rw_log.delete();
            starts <= 0;
        end
        if (scl_q && scl_io && sda_q && !sda_io) begin  // START or repeated START
            starts  <= starts + 1;
            mode    <= m_addr;
            bit_cnt <= '0;
            sda_low <= 1'b0;
        end else if (scl_q && scl_io && !sda_q && sda_io) begin  // STOP
            mode    <= m_idle;
            sda_low <= 1'b0;
        end else if (!scl_q && scl_io) begin  // SCL rose, sample
            if ((mode == m_addr || mode == m_write) && bit_cnt < 8) begin
                shreg   <= {shreg[6:0], sda_io};
                bit_cnt <= bit_cnt + 1'b1;
            end else if (mode == m_read) begin
                if (bit_cnt < 8) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end else begin
                    ack_log.push_back(sda_io);
                    if (!sda_io) begin
                        rd_idx  <= rd_idx + 1'b1;
                        tx      <= rd_first ^ (rd_idx + 1'b1);
                        bit_cnt <= '0;
                    end else begin
                        mode <= m_idle;  // NACK, wait for STOP
                    end
                end
            end
        end else if (scl_q && !scl_io) begin  // SCL fell, drive
            case (mode)
                m_addr: begin
                    if (bit_cnt == 8) begin
                        if (shreg[7:1] == addr) begin
                            rw_log.push_back(shreg[0]);
                            sda_low <= 1'b1;
                            bit_cnt <= 4'd9;
                        end else begin
                            mode <= m_idle;
                        end
                    end else if (bit_cnt == 9) begin
                        bit_cnt <= '0;
                        if (shreg[0]) begin
                            mode    <= m_read;
                            rd_idx  <= '0;
                            tx      <= rd_first;
                            sda_low <= ~rd_first[7];
                        end else begin
                            mode    <= m_write;
                            sda_low <= 1'b0;
                        end
                    end
                end
                m_write: begin
                    if (bit_cnt == 8) begin
                        if (wr_log.size() == int'(nack_at)) begin
                            mode <= m_idle;  // refuse this byte
                        end else begin
                            sda_low <= 1'b1;
                            bit_cnt <= 4'd9;
                        end
                        wr_log.push_back(shreg);
                    end else if (bit_cnt == 9) begin
                        sda_low <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                m_read: begin
                    if (bit_cnt < 8)
                        sda_low <= ~tx[3'd7 - bit_cnt[2:0]];
                    else
                        sda_low <= 1'b0;  // master's ACK slot
                end
                default: sda_low <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* dv/i2c_master_checker.sv */
/*
 * I2C master protocol checks
 * done pulse width, read stream hold and stream idle while not busy
 */
`timescale 1ns/100ps
`default_nettype none

module i2c_master_checker (
    input wire logic                       clk,
    input wire logic                       rst_n,
    input wire i2c_xfer_pkg::xfer_status_t status,
    input wire logic                       wr_ready,
    input wire logic                       rd_valid,
    input wire logic                       rd_ready
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        status.done |=> !status.done)
        else $error("done stayed high for more than one cycle");

    rd_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid)
        else $error("rd_valid dropped before rd_ready");

    quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !status.busy |-> !wr_ready && !rd_valid)
        else $error("stream handshake active while not busy");

endmodule

bind i2c_master i2c_master_checker checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .status   (status),
    .wr_ready (wr_ready),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready)
);

`default_nettype wire

/* dv/tb_i2c_master.sv */
/*
 * I2C master testbench
 * runs a table of write, read and combined transfers against the target
 * model with random stream stalls and checks data, ACKs and NACK flags
 */
`timescale 1ns/100ps
`default_nettype none

`include "i2c_consts.svh"

module tb_i2c_master;
    import i2c_xfer_pkg::*;

    localparam logic [6:0] target_addr = 7'h52;
    localparam int         n_rows      = 7;

    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] wr_len;
        logic [7:0] rd_len;
        logic [7:0] nack_at;  // ff means the target ACKs every byte
        logic       exp_na;
        logic       exp_nd;
    } row_t;

    row_t rows [0:n_rows-1];

    logic         clk;
    logic         rst_n;
    logic         start;
    xfer_cmd_t    cmd;
    xfer_status_t status;
    logic [7:0]   wr_data;
    logic         wr_valid;
    logic         wr_ready;
    logic [7:0]   rd_data;
    logic         rd_valid;
    logic         rd_ready;
    logic         clear;
    logic [7:0]   nack_at;
    tri1          sda;  // pull-ups
    tri1          scl;

    int cycles;
    int limit;
    int wr_sent;
    int rd_got;

    i2c_master uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .cmd      (cmd),
        .status   (status),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .sda_io   (sda),
        .scl_io   (scl)
    );

    i2c_slave_model #(.addr(target_addr)) target (
        .clk     (clk),
        .clear   (clear),
        .nack_at (nack_at),
        .sda_io  (sda),
        .scl_io  (scl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("TEST FAILED");
            $fatal(1, "timeout: transfers did not finish within %0d cycles", limit);
        end
    end

    task automatic compare(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // stream activity for one falling edge with random stalls
    task automatic serve_streams(input int r);
        logic go;
        logic rdy;
        go       = (wr_sent < int'(rows[r].wr_len)) && ($urandom_range(2, 0) != 0);
        wr_valid = go;
        wr_data  = 8'(8'h30 + r * 16 + wr_sent);
        if (go && wr_ready)
            wr_sent++;  // taken on the coming rising edge
        rdy      = ($urandom_range(2, 0) != 0);
        rd_ready = rdy;
        if (rd_valid && rdy) begin
            compare("rd_data", int'(rd_data), int'(8'hA5 ^ 8'(rd_got)));
            rd_got++;
        end
    endtask

    task automatic run_row(input int r);
        logic done_seen;
        int   exp_wr;
        int   exp_rd;
        int   exp_rw;
        int   waited;
        bit   clean;
        clean  = !rows[r].exp_na && !rows[r].exp_nd;
        exp_wr = rows[r].exp_na ? 0 :
                 (rows[r].nack_at != 8'hFF) ? int'(rows[r].nack_at) + 1 : int'(rows[r].wr_len);
        exp_rd = clean ? int'(rows[r].rd_len) : 0;
        wr_sent = 0;
        rd_got  = 0;
        @(negedge clk);
        cmd     = '{addr: rows[r].addr, wr_len: rows[r].wr_len, rd_len: rows[r].rd_len};
        nack_at = rows[r].nack_at;
        start   = 1'b1;
        clear   = 1'b1;
        done_seen = 1'b0;
        waited    = 0;
        while (!done_seen) begin
            @(negedge clk);
            start = 1'b0;
            clear = 1'b0;
            waited++;
            if (waited <= 3)
                compare("busy after start", int'(status.busy), int'(waited == 3));  // 3-cycle launch
            serve_streams(r);
            done_seen = status.done;
        end
        compare("nack_addr", int'(status.nack_addr), int'(rows[r].exp_na));
        compare("nack_data", int'(status.nack_data), int'(rows[r].exp_nd));
        wr_valid = 1'b0;
        rd_ready = 1'b0;
        compare("write bytes accepted", wr_sent, exp_wr);
        compare("read bytes delivered", rd_got, exp_rd);
        compare("target write log size", target.wr_log.size(), exp_wr);
        for (int i = 0; i < exp_wr; i++)
            compare("target write byte", int'(target.wr_log[i]), int'(8'(8'h30 + r * 16 + i)));
        compare("master ACK count", target.ack_log.size(), exp_rd);
        for (int i = 0; i < exp_rd; i++)
            compare("master ACK bit", int'(target.ack_log[i]), int'(i == exp_rd - 1));
        exp_rw = rows[r].exp_na ? 0 :
                 int'(rows[r].wr_len != 0) + int'(clean && rows[r].rd_len != 0);
        compare("address phases", target.rw_log.size(), exp_rw);
        if (exp_rw > 0 && rows[r].wr_len != 0)
            compare("write R/W bit", int'(target.rw_log[0]), 0);
        if (exp_rw > 0 && rows[r].rd_len != 0 && clean)
            compare("read R/W bit", int'(target.rw_log[exp_rw - 1]), 1);
        compare("START count", target.starts, (exp_rw == 2) ? 2 : 1);
        @(negedge clk);
        compare("busy after done", int'(status.busy), 0);
        repeat (2) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h4fc3999c));
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = '0;
        wr_data  = '0;
        wr_valid = 1'b0;
        rd_ready = 1'b0;
        clear    = 1'b0;
        nack_at  = 8'hFF;
        cycles   = 0;
        rows[0] = '{target_addr, 8'd3, 8'd0, 8'hFF, 1'b0, 1'b0};  // write
        rows[1] = '{target_addr, 8'd0, 8'd4, 8'hFF, 1'b0, 1'b0};  // read
        rows[2] = '{target_addr, 8'd2, 8'd3, 8'hFF, 1'b0, 1'b0};  // combined
        rows[3] = '{7'h13,       8'd2, 8'd0, 8'hFF, 1'b1, 1'b0};  // nobody there
        rows[4] = '{target_addr, 8'd4, 8'd0, 8'd1,  1'b0, 1'b1};  // second byte refused
        rows[5] = '{target_addr, 8'd5, 8'd2, 8'hFF, 1'b0, 1'b0};
        rows[6] = '{target_addr, 8'd0, 8'd1, 8'hFF, 1'b0, 1'b0};  // single byte, NACK only
        limit = 2000;
        for (int r = 0; r < n_rows; r++)
            limit += (int'(rows[r].wr_len) + int'(rows[r].rd_len)) * 200;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/i2c_bus_pkg.sv
hdl/i2c_xfer_pkg.sv
hdl/i2c_pin_sync.sv
hdl/i2c_bit_timer.sv
hdl/i2c_cmd_regs.sv
hdl/i2c_bit_sequencer.sv
hdl/i2c_master.sv
dv/i2c_slave_model.sv
dv/i2c_master_checker.sv
dv/tb_i2c_master.sv

/* Makefile */
# Verilator build of the I2C master testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/sim_i2c

obj_dir/sim_i2c: flist.f hdl/*.sv hdl/*.svh dv/*.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_i2c_master -f flist.f -o sim_i2c

run: compile
	./obj_dir/sim_i2c

clean:
	rm -rf obj_dir
